// ==== src/ctrlPkg.sv ====
package ctrlPkg;

    // Field types of the instruction word
    typedef logic [31:0] instrT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;
    typedef logic [4:0]  fieldT;      // rt or sa
    typedef logic [4:0]  aluCtrlT;
    typedef logic [3:0]  regTypesT;   // Register usage class for hazard logic

    // Two-bit control fields
    typedef logic [1:0] regDstT;
    typedef logic [1:0] dataTypeT;
    typedef logic [1:0] hiLoWriteT;

    localparam regDstT regDstRt = 2'd0;
    localparam regDstT regDstRd = 2'd1;
    localparam regDstT regDstRa = 2'd2;   // jal link register

    localparam dataTypeT dataWord = 2'd0;
    localparam dataTypeT dataHalf = 2'd1;
    localparam dataTypeT dataByte = 2'd2;

    localparam hiLoWriteT hiLoNone = 2'd0;
    localparam hiLoWriteT hiLoHi   = 2'd1;
    localparam hiLoWriteT hiLoLo   = 2'd2;
    localparam hiLoWriteT hiLoBoth = 2'd3;

    // Opcodes
    localparam opcodeT opSpecial  = 6'b000000;
    localparam opcodeT opRegimm   = 6'b000001;
    localparam opcodeT opJ        = 6'b000010;
    localparam opcodeT opJal      = 6'b000011;
    localparam opcodeT opBeq      = 6'b000100;
    localparam opcodeT opBne      = 6'b000101;
    localparam opcodeT opBlez     = 6'b000110;
    localparam opcodeT opBgtz     = 6'b000111;
    localparam opcodeT opAddi     = 6'b001000;
    localparam opcodeT opAddiu    = 6'b001001;
    localparam opcodeT opSlti     = 6'b001010;
    localparam opcodeT opSltiu    = 6'b001011;
    localparam opcodeT opAndi     = 6'b001100;
    localparam opcodeT opOri      = 6'b001101;
    localparam opcodeT opXori     = 6'b001110;
    localparam opcodeT opLui      = 6'b001111;
    localparam opcodeT opSpecial2 = 6'b011100;
    localparam opcodeT opSpecial3 = 6'b011111;   // seb, seh
    localparam opcodeT opLb       = 6'b100000;
    localparam opcodeT opLh       = 6'b100001;
    localparam opcodeT opLw       = 6'b100011;
    localparam opcodeT opSb       = 6'b101000;
    localparam opcodeT opSh       = 6'b101001;
    localparam opcodeT opSw       = 6'b101011;

    // Special table funct codes
    localparam functT fnSll   = 6'b000000;
    localparam functT fnSrl   = 6'b000010;   // rotr when bit 21 set
    localparam functT fnSra   = 6'b000011;
    localparam functT fnSllv  = 6'b000100;
    localparam functT fnSrlv  = 6'b000110;   // rotrv when sa is 1
    localparam functT fnSrav  = 6'b000111;
    localparam functT fnJr    = 6'b001000;
    localparam functT fnMovz  = 6'b001010;
    localparam functT fnMovn  = 6'b001011;
    localparam functT fnMfhi  = 6'b010000;
    localparam functT fnMthi  = 6'b010001;
    localparam functT fnMflo  = 6'b010010;
    localparam functT fnMtlo  = 6'b010011;
    localparam functT fnMult  = 6'b011000;
    localparam functT fnMultu = 6'b011001;
    localparam functT fnAdd   = 6'b100000;
    localparam functT fnAddu  = 6'b100001;
    localparam functT fnSub   = 6'b100010;
    localparam functT fnAnd   = 6'b100100;
    localparam functT fnOr    = 6'b100101;
    localparam functT fnXor   = 6'b100110;
    localparam functT fnNor   = 6'b100111;
    localparam functT fnSlt   = 6'b101010;
    localparam functT fnSltu  = 6'b101011;

    // Special2 table funct codes
    localparam functT fnMadd = 6'b000000;
    localparam functT fnMul  = 6'b000010;
    localparam functT fnMsub = 6'b000100;

    // Sub-field selectors
    localparam fieldT rtBltz  = 5'd0;
    localparam fieldT rtBgez  = 5'd1;
    localparam fieldT saSrlv  = 5'd0;
    localparam fieldT saRotrv = 5'd1;
    localparam fieldT saSeb   = 5'd16;
    localparam fieldT saSeh   = 5'd24;

    // ALU operation codes, shared with the ALU
    localparam aluCtrlT aluAdd  = 5'd0;
    localparam aluCtrlT aluSub  = 5'd1;
    localparam aluCtrlT aluMult = 5'd2;
    localparam aluCtrlT aluAnd  = 5'd3;
    localparam aluCtrlT aluOr   = 5'd4;
    localparam aluCtrlT aluNor  = 5'd5;
    localparam aluCtrlT aluXor  = 5'd6;
    localparam aluCtrlT aluSll  = 5'd7;
    localparam aluCtrlT aluSrl  = 5'd8;
    localparam aluCtrlT aluRotr = 5'd9;
    localparam aluCtrlT aluSlt  = 5'd10;
    localparam aluCtrlT aluMovn = 5'd11;
    localparam aluCtrlT aluMovz = 5'd12;
    localparam aluCtrlT aluSra  = 5'd13;
    localparam aluCtrlT aluSltu = 5'd14;
    localparam aluCtrlT aluMthi = 5'd15;
    localparam aluCtrlT aluMtlo = 5'd16;
    localparam aluCtrlT aluMfhi = 5'd17;
    localparam aluCtrlT aluMflo = 5'd18;
    localparam aluCtrlT aluMul  = 5'd19;
    localparam aluCtrlT aluMadd = 5'd20;
    localparam aluCtrlT aluMsub = 5'd21;
    localparam aluCtrlT aluSeh  = 5'd22;
    localparam aluCtrlT aluSeb  = 5'd23;
    localparam aluCtrlT aluBgez = 5'd24;
    localparam aluCtrlT aluBltz = 5'd25;
    localparam aluCtrlT aluNone = 5'd31;

    // Register usage classes
    localparam regTypesT regTypeAlu    = 4'd0;    // rs, rt read, rd written
    localparam regTypesT regTypeImm    = 4'd1;
    localparam regTypesT regTypeHiLoWr = 4'd2;
    localparam regTypesT regTypeLoad   = 4'd3;
    localparam regTypesT regTypeStore  = 4'd4;
    localparam regTypesT regTypeBrRs   = 4'd5;    // Compare rs with zero
    localparam regTypesT regTypeBrRsRt = 4'd6;
    localparam regTypesT regTypeJump   = 4'd7;
    localparam regTypesT regTypeJr     = 4'd8;
    localparam regTypesT regTypeRtRd   = 4'd9;    // Immediate shifts, seb, seh
    localparam regTypesT regTypeHiLoRd = 4'd10;
    localparam regTypesT regTypeNop    = 4'd11;

    // Decoder view of the instruction
    typedef struct packed {
        opcodeT opcode;
        logic   rsBit21;
        fieldT  rt;
        fieldT  sa;
        functT  funct;
    } instrFieldsT;

    typedef struct packed {
        regDstT    regDst;
        logic      aluSrc;      // Immediate as second operand
        logic      aluSrc2;     // Shift amount or jump target path
        logic      memToReg;
        logic      regWrite;
        logic      memRead;
        logic      memWrite;
        logic      branch;
        logic      jump;
        dataTypeT  dataType;
        hiLoWriteT hiLoWrite;
        aluCtrlT   aluControl;
        logic      signExtend;
        logic      index;
        regTypesT  regTypes;
    } ctrlT;

    // Nothing happens
    localparam ctrlT ctrlNone = '{
        regDst:     regDstRt,
        aluSrc:     1'b0,
        aluSrc2:    1'b0,
        memToReg:   1'b0,
        regWrite:   1'b0,
        memRead:    1'b0,
        memWrite:   1'b0,
        branch:     1'b0,
        jump:       1'b0,
        dataType:   dataWord,
        hiLoWrite:  hiLoNone,
        aluControl: aluNone,
        signExtend: 1'b0,
        index:      1'b0,
        regTypes:   '0
    };

endpackage

// ==== src/functDecoder.sv ====
`timescale 1ns/1ns

module functDecoder (
    input  ctrlPkg::functT funct,
    input  logic           rsBit21,
    input  ctrlPkg::fieldT sa,
    output ctrlPkg::ctrlT  rResult,
    output ctrlPkg::ctrlT  special2Result
);

    // Special table, used when opcode is 0
    always_comb begin : specialDecode
        logic immShift;

        immShift = 1'b0;
        rResult = ctrlPkg::ctrlNone;
        rResult.regDst = ctrlPkg::regDstRd;
        rResult.regWrite = 1'b1;
        rResult.regTypes = ctrlPkg::regTypeAlu;

        case (funct)
            ctrlPkg::fnAdd, ctrlPkg::fnAddu: rResult.aluControl = ctrlPkg::aluAdd;
            ctrlPkg::fnSub:  rResult.aluControl = ctrlPkg::aluSub;
            ctrlPkg::fnAnd:  rResult.aluControl = ctrlPkg::aluAnd;
            ctrlPkg::fnOr:   rResult.aluControl = ctrlPkg::aluOr;
            ctrlPkg::fnNor:  rResult.aluControl = ctrlPkg::aluNor;
            ctrlPkg::fnXor:  rResult.aluControl = ctrlPkg::aluXor;
            ctrlPkg::fnSlt:  rResult.aluControl = ctrlPkg::aluSlt;
            ctrlPkg::fnSltu: rResult.aluControl = ctrlPkg::aluSltu;
            ctrlPkg::fnMovn: rResult.aluControl = ctrlPkg::aluMovn;
            ctrlPkg::fnMovz: rResult.aluControl = ctrlPkg::aluMovz;
            ctrlPkg::fnSllv: rResult.aluControl = ctrlPkg::aluSll;
            ctrlPkg::fnSrav: rResult.aluControl = ctrlPkg::aluSra;
            ctrlPkg::fnSll: begin
                rResult.aluControl = ctrlPkg::aluSll;
                immShift = 1'b1;
            end
            ctrlPkg::fnSra: begin
                rResult.aluControl = ctrlPkg::aluSra;
                immShift = 1'b1;
            end
            ctrlPkg::fnSrl: begin
                // Bit 21 turns srl into rotr
                rResult.aluControl = rsBit21 ? ctrlPkg::aluRotr : ctrlPkg::aluSrl;
                immShift = 1'b1;
            end
            ctrlPkg::fnSrlv: begin
                case (sa)
                    ctrlPkg::saSrlv:  rResult.aluControl = ctrlPkg::aluSrl;
                    ctrlPkg::saRotrv: rResult.aluControl = ctrlPkg::aluRotr;
                    default:          rResult = ctrlPkg::ctrlNone;
                endcase
            end
            ctrlPkg::fnMult, ctrlPkg::fnMultu: begin
                rResult.aluControl = ctrlPkg::aluMult;
                rResult.hiLoWrite = ctrlPkg::hiLoBoth;
                rResult.regTypes = ctrlPkg::regTypeHiLoWr;
            end
            ctrlPkg::fnMthi: begin
                rResult.aluControl = ctrlPkg::aluMthi;
                rResult.hiLoWrite = ctrlPkg::hiLoHi;
                rResult.regTypes = ctrlPkg::regTypeHiLoWr;
            end
            ctrlPkg::fnMtlo: begin
                rResult.aluControl = ctrlPkg::aluMtlo;
                rResult.hiLoWrite = ctrlPkg::hiLoLo;
                rResult.regTypes = ctrlPkg::regTypeHiLoWr;
            end
            ctrlPkg::fnMfhi: begin
                rResult.aluControl = ctrlPkg::aluMfhi;
                rResult.regTypes = ctrlPkg::regTypeHiLoRd;
            end
            ctrlPkg::fnMflo: begin
                rResult.aluControl = ctrlPkg::aluMflo;
                rResult.regTypes = ctrlPkg::regTypeHiLoRd;
            end
            ctrlPkg::fnJr: begin
                rResult.jump = 1'b1;              // ALU unused
                rResult.regTypes = ctrlPkg::regTypeJr;
            end
            default: ;                            // Base flags with aluNone
        endcase

        // Shift amount comes from sa
        if (immShift) begin
            rResult.aluSrc2 = 1'b1;
            rResult.index = 1'b1;
            rResult.regTypes = ctrlPkg::regTypeRtRd;
        end
    end

    // Special2 table, used when opcode is 28
    always_comb begin
        special2Result = ctrlPkg::ctrlNone;
        special2Result.regDst = ctrlPkg::regDstRd;
        special2Result.regWrite = 1'b1;
        special2Result.regTypes = ctrlPkg::regTypeAlu;

        case (funct)
            ctrlPkg::fnMul: special2Result.aluControl = ctrlPkg::aluMul;
            ctrlPkg::fnMadd: begin
                special2Result.aluControl = ctrlPkg::aluMadd;
                special2Result.hiLoWrite = ctrlPkg::hiLoBoth;
                special2Result.regTypes = ctrlPkg::regTypeHiLoWr;
            end
            ctrlPkg::fnMsub: begin
                special2Result.aluControl = ctrlPkg::aluMsub;
                special2Result.hiLoWrite = ctrlPkg::hiLoBoth;
                special2Result.regTypes = ctrlPkg::regTypeHiLoWr;
            end
            default: ;
        endcase
    end

endmodule

// ==== src/opcodeDecoder.sv ====
`timescale 1ns/1ns

module opcodeDecoder (
    input  ctrlPkg::instrFieldsT fields,
    output ctrlPkg::ctrlT        ctrl
);

    ctrlPkg::ctrlT rResult;
    ctrlPkg::ctrlT special2Result;

    // Access width, shared by loads and stores
    function automatic ctrlPkg::dataTypeT memDataType(input ctrlPkg::opcodeT opcode);
        ctrlPkg::dataTypeT dt;

        case (opcode)
            ctrlPkg::opLh, ctrlPkg::opSh: dt = ctrlPkg::dataHalf;
            ctrlPkg::opLb, ctrlPkg::opSb: dt = ctrlPkg::dataByte;
            default:                      dt = ctrlPkg::dataWord;
        endcase
        return dt;
    endfunction

    functDecoder functDecoder_i (
        .funct          (fields.funct),
        .rsBit21        (fields.rsBit21),
        .sa             (fields.sa),
        .rResult        (rResult),
        .special2Result (special2Result)
    );

    always_comb begin
        ctrl = ctrlPkg::ctrlNone;

        if (fields == '0) begin
            ctrl.regTypes = ctrlPkg::regTypeNop;  // nop
        end else begin
            case (fields.opcode)
                ctrlPkg::opSpecial:  ctrl = rResult;
                ctrlPkg::opSpecial2: ctrl = special2Result;

                ctrlPkg::opLw, ctrlPkg::opLh, ctrlPkg::opLb: begin
                    ctrl.regDst = ctrlPkg::regDstRt;
                    ctrl.aluSrc = 1'b1;
                    ctrl.memToReg = 1'b1;
                    ctrl.regWrite = 1'b1;
                    ctrl.memRead = 1'b1;
                    ctrl.dataType = memDataType(fields.opcode);
                    ctrl.regTypes = ctrlPkg::regTypeLoad;
                end

                ctrlPkg::opLui: begin
                    ctrl.regDst = ctrlPkg::regDstRt;
                    ctrl.aluSrc = 1'b1;
                    ctrl.regWrite = 1'b1;
                    ctrl.regTypes = ctrlPkg::regTypeLoad;  // Writes rt only, like a load
                end

                ctrlPkg::opSw, ctrlPkg::opSh, ctrlPkg::opSb: begin
                    ctrl.aluSrc = 1'b1;
                    ctrl.memWrite = 1'b1;
                    ctrl.dataType = memDataType(fields.opcode);
                    ctrl.regTypes = ctrlPkg::regTypeStore;
                end

                ctrlPkg::opBeq, ctrlPkg::opBne: begin
                    ctrl.branch = 1'b1;
                    ctrl.regTypes = ctrlPkg::regTypeBrRsRt;
                end

                ctrlPkg::opBgtz, ctrlPkg::opBlez: begin
                    ctrl.branch = 1'b1;
                    ctrl.regTypes = ctrlPkg::regTypeBrRs;
                end

                ctrlPkg::opRegimm: begin
                    // rt picks bgez or bltz
                    if (fields.rt == ctrlPkg::rtBgez || fields.rt == ctrlPkg::rtBltz) begin
                        ctrl.branch = 1'b1;
                        ctrl.regTypes = ctrlPkg::regTypeBrRs;
                        ctrl.aluControl = (fields.rt == ctrlPkg::rtBgez) ?
                                          ctrlPkg::aluBgez : ctrlPkg::aluBltz;
                    end
                end

                ctrlPkg::opAddi, ctrlPkg::opAddiu, ctrlPkg::opSlti, ctrlPkg::opSltiu,
                ctrlPkg::opAndi, ctrlPkg::opOri, ctrlPkg::opXori: begin
                    ctrl.regDst = ctrlPkg::regDstRt;
                    ctrl.aluSrc = 1'b1;
                    ctrl.regWrite = 1'b1;
                    ctrl.regTypes = ctrlPkg::regTypeImm;
                    // Logic immediates only
                    ctrl.signExtend = fields.opcode inside {ctrlPkg::opAndi, ctrlPkg::opOri,
                                                            ctrlPkg::opXori};
                end

                ctrlPkg::opSpecial3: begin
                    if (fields.sa == ctrlPkg::saSeh || fields.sa == ctrlPkg::saSeb) begin
                        ctrl.regDst = ctrlPkg::regDstRd;
                        ctrl.regWrite = 1'b1;
                        ctrl.regTypes = ctrlPkg::regTypeRtRd;
                        ctrl.aluControl = (fields.sa == ctrlPkg::saSeh) ?
                                          ctrlPkg::aluSeh : ctrlPkg::aluSeb;
                    end
                end

                ctrlPkg::opJ, ctrlPkg::opJal: begin
                    ctrl.jump = 1'b1;
                    ctrl.aluSrc2 = 1'b1;
                    ctrl.regTypes = ctrlPkg::regTypeJump;
                    if (fields.opcode == ctrlPkg::opJal) begin
                        ctrl.regDst = ctrlPkg::regDstRa;   // Link into ra
                        ctrl.regWrite = 1'b1;
                    end
                end

                default: ;                        // Unknown opcode
            endcase
        end
    end

endmodule

// ==== src/controlUnit.sv ====
`timescale 1ns/1ns

module controlUnit (
    input  logic           clk,
    input  logic           rstN,
    input  logic           req,
    input  ctrlPkg::instrT instr,
    output logic           ack,
    output ctrlPkg::ctrlT  ctrl
);

    // Four-phase handshake, one item in flight
    typedef enum logic {
        idle,
        acked
    } hsStateT;

    hsStateT              state;
    ctrlPkg::instrFieldsT fields;
    ctrlPkg::ctrlT        decoded;

    // Only the bits the decoder looks at
    assign fields.opcode  = instr[31:26];
    assign fields.rsBit21 = instr[21];
    assign fields.rt      = instr[20:16];
    assign fields.sa      = instr[10:6];
    assign fields.funct   = instr[5:0];

    opcodeDecoder opcodeDecoder_i (
        .fields (fields),
        .ctrl   (decoded)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= idle;
            ctrl <= ctrlPkg::ctrlNone;
        end else begin
            case (state)
                idle: begin
                    if (req) begin
                        ctrl <= decoded;    // Capture on accept
                        state <= acked;
                    end
                end
                acked: begin
                    // ctrl holds until req drops
                    if (!req) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // ack follows the state register, one cycle after req is sampled
    assign ack = (state == acked);

endmodule

// ==== sim/tbRefModel.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Expected control bundle, built from the decode rules
function automatic ctrlPkg::ctrlT expectedCtrl(input ctrlPkg::instrT w);
    ctrlPkg::ctrlT e;
    logic [5:0]    op;
    logic [5:0]    fn;
    logic [4:0]    rt;
    logic [4:0]    sa;

    op = w[31:26];
    rt = w[20:16];
    sa = w[10:6];
    fn = w[5:0];
    e = ctrlPkg::ctrlNone;

    if (op == 6'd0 && !w[21] && rt == 5'd0 && sa == 5'd0 && fn == 6'd0) begin
        e.regTypes = 4'd11;                     // nop
    end else if (op == 6'h00) begin
        e.regDst = ctrlPkg::regDstRd;
        e.regWrite = 1'b1;
        case (fn)
            6'h20, 6'h21: e.aluControl = ctrlPkg::aluAdd;
            6'h22: e.aluControl = ctrlPkg::aluSub;
            6'h24: e.aluControl = ctrlPkg::aluAnd;
            6'h25: e.aluControl = ctrlPkg::aluOr;
            6'h26: e.aluControl = ctrlPkg::aluXor;
            6'h27: e.aluControl = ctrlPkg::aluNor;
            6'h2a: e.aluControl = ctrlPkg::aluSlt;
            6'h2b: e.aluControl = ctrlPkg::aluSltu;
            6'h0a: e.aluControl = ctrlPkg::aluMovz;
            6'h0b: e.aluControl = ctrlPkg::aluMovn;
            6'h00, 6'h04: e.aluControl = ctrlPkg::aluSll;
            6'h03, 6'h07: e.aluControl = ctrlPkg::aluSra;
            6'h02: e.aluControl = w[21] ? ctrlPkg::aluRotr : ctrlPkg::aluSrl;
            6'h06: e.aluControl = (sa == 5'd1) ? ctrlPkg::aluRotr : ctrlPkg::aluSrl;
            6'h18, 6'h19: e.aluControl = ctrlPkg::aluMult;
            6'h10: e.aluControl = ctrlPkg::aluMfhi;
            6'h11: e.aluControl = ctrlPkg::aluMthi;
            6'h12: e.aluControl = ctrlPkg::aluMflo;
            6'h13: e.aluControl = ctrlPkg::aluMtlo;
            default: ;                          // jr and unknown keep aluNone
        endcase
        case (fn)
            6'h18, 6'h19: {e.hiLoWrite, e.regTypes} = {ctrlPkg::hiLoBoth, 4'd2};
            6'h11: {e.hiLoWrite, e.regTypes} = {ctrlPkg::hiLoHi, 4'd2};
            6'h13: {e.hiLoWrite, e.regTypes} = {ctrlPkg::hiLoLo, 4'd2};
            6'h10, 6'h12: e.regTypes = 4'd10;
            6'h08: {e.jump, e.regTypes} = {1'b1, 4'd8};
            6'h00, 6'h02, 6'h03: {e.aluSrc2, e.index, e.regTypes} = {2'b11, 4'd9};
            default: ;
        endcase
        if (fn == 6'h06 && sa > 5'd1) e = ctrlPkg::ctrlNone;   // Bad srlv sub-field
    end else if (op == 6'h1c) begin
        e.regDst = ctrlPkg::regDstRd;
        e.regWrite = 1'b1;
        case (fn)
            6'h02: e.aluControl = ctrlPkg::aluMul;
            6'h00: {e.aluControl, e.hiLoWrite, e.regTypes} = {ctrlPkg::aluMadd, 2'd3, 4'd2};
            6'h04: {e.aluControl, e.hiLoWrite, e.regTypes} = {ctrlPkg::aluMsub, 2'd3, 4'd2};
            default: ;
        endcase
    end else begin
        case (op)
            6'h23, 6'h21, 6'h20: begin
                {e.aluSrc, e.memToReg, e.regWrite, e.memRead} = 4'b1111;
                e.dataType = (op == 6'h23) ? 2'd0 : (op == 6'h21) ? 2'd1 : 2'd2;
                e.regTypes = 4'd3;
            end
            6'h0f: {e.aluSrc, e.regWrite, e.regTypes} = {2'b11, 4'd3};   // lui
            6'h2b, 6'h29, 6'h28: begin
                {e.aluSrc, e.memWrite, e.regTypes} = {2'b11, 4'd4};
                e.dataType = (op == 6'h2b) ? 2'd0 : (op == 6'h29) ? 2'd1 : 2'd2;
            end
            6'h04, 6'h05: {e.branch, e.regTypes} = {1'b1, 4'd6};
            6'h06, 6'h07: {e.branch, e.regTypes} = {1'b1, 4'd5};
            6'h01: begin
                if (rt == 5'd1) {e.branch, e.regTypes, e.aluControl} = {1'b1, 4'd5, 5'd24};
                if (rt == 5'd0) {e.branch, e.regTypes, e.aluControl} = {1'b1, 4'd5, 5'd25};
            end
            6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e: begin
                {e.aluSrc, e.regWrite, e.regTypes} = {2'b11, 4'd1};
                e.signExtend = (op >= 6'h0c);   // andi, ori, xori
            end
            6'h1f: begin
                if (sa == 5'd24 || sa == 5'd16) begin
                    {e.regDst, e.regWrite, e.regTypes} = {ctrlPkg::regDstRd, 1'b1, 4'd9};
                    e.aluControl = (sa == 5'd24) ? ctrlPkg::aluSeh : ctrlPkg::aluSeb;
                end
            end
            6'h02: {e.jump, e.aluSrc2, e.regTypes} = {2'b11, 4'd7};
            6'h03: begin
                {e.jump, e.aluSrc2, e.regWrite, e.regTypes} = {3'b111, 4'd7};
                e.regDst = ctrlPkg::regDstRa;
            end
            default: ;
        endcase
    end
    return e;
endfunction

`endif

// ==== sim/tbControlUnit.sv ====
`timescale 1ns/1ns

module tbControlUnit;

    logic           clk;
    logic           rstN;
    logic           req;
    ctrlPkg::instrT instr;
    logic           ack;
    ctrlPkg::ctrlT  ctrl;

    int     errors;
    int     checks;
    integer seed;

    `include "tbRefModel.svh"

    controlUnit controlUnit_i (
        .clk   (clk),
        .rstN  (rstN),
        .req   (req),
        .instr (instr),
        .ack   (ack),
        .ctrl  (ctrl)
    );

    always #2 clk = ~clk;

    // Handshake rules
    ackAfterReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) |-> $past(req) && req)
        else begin
            errors++;
            $display("Protocol error: ack rose without req sampled high the cycle before");
        end
    reqAccepted: assert property (@(posedge clk) disable iff (!rstN) req && !ack |=> ack)
        else begin
            errors++;
            $display("Protocol error: req was high in idle but ack did not follow");
        end
    ackHeld: assert property (@(posedge clk) disable iff (!rstN) ack && req |=> ack)
        else begin
            errors++;
            $display("Protocol error: ack fell while req was still high");
        end
    ackAfterRelease: assert property (@(posedge clk) disable iff (!rstN)
        $fell(ack) |-> !$past(req))
        else begin
            errors++;
            $display("Protocol error: ack fell before req was sampled low");
        end
    ctrlStable: assert property (@(posedge clk) disable iff (!rstN)
        ack && $past(ack) |-> $stable(ctrl))
        else begin
            errors++;
            $display("Protocol error: ctrl changed while ack was high");
        end

    task automatic finishRun();
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    // Polls at falling edges until ack reaches level
    task automatic waitAck(input logic level);
        int cycles;

        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (ack !== level && cycles < 50);
        if (ack !== level) begin
            errors++;
            $display("Timeout: ack did not reach %0d within 50 cycles", level);
            finishRun();
        end
    endtask

    task automatic checkCtrl(input ctrlPkg::ctrlT exp, input ctrlPkg::instrT w);
        checks++;
        assert (ctrl === exp) else begin
            errors++;
            $display("** Error: ctrl for instr 0x%h expected 0x%h got 0x%h", w, exp, ctrl);
        end
    endtask

    // One four-phase transfer, req held for hold extra cycles
    task automatic sendInstr(input ctrlPkg::instrT w, input int hold);
        ctrlPkg::ctrlT exp;

        exp = expectedCtrl(w);
        @(posedge clk);
        instr <= w;
        req <= 1'b1;
        waitAck(1'b1);
        checkCtrl(exp, w);
        @(posedge clk);
        instr <= ~w;                // Requester owns instr again once ack is seen
        repeat (hold) begin
            @(negedge clk);
            checkCtrl(exp, w);
        end
        @(posedge clk);
        req <= 1'b0;
        waitAck(1'b0);
    endtask

    function automatic ctrlPkg::instrT makeInstr(input logic [5:0] op, input logic [4:0] rs,
                                                 input logic [4:0] rt, input logic [4:0] rd,
                                                 input logic [4:0] sa, input logic [5:0] fn);
        return {op, rs, rt, rd, sa, fn};
    endfunction

    initial begin
        int hold;

        clk = 1'b0;
        rstN = 1'b0;
        req = 1'b0;
        instr = '0;
        errors = 0;
        checks = 0;
        seed = 32'heebc;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checks++;
        assert (ack === 1'b0) else begin
            errors++;
            $display("** Error: ack after reset expected 0x0 got 0x%h", ack);
        end
        checkCtrl(ctrlPkg::ctrlNone, instr);

        // Special and special2 tables, every funct
        for (int f = 0; f < 64; f++) begin
            sendInstr(makeInstr(6'h00, 5'd2, 5'd4, 5'd3, 5'd0, f[5:0]), 0);
        end
        for (int f = 0; f < 64; f++) begin
            sendInstr(makeInstr(6'h1c, 5'd2, 5'd4, 5'd3, 5'd0, f[5:0]), 0);
        end
        sendInstr(makeInstr(6'h00, 5'd1, 5'd4, 5'd3, 5'd5, 6'h02), 0);   // rotr
        sendInstr(makeInstr(6'h00, 5'd2, 5'd4, 5'd3, 5'd1, 6'h06), 0);   // rotrv
        sendInstr(makeInstr(6'h00, 5'd2, 5'd4, 5'd3, 5'd9, 6'h06), 0);
        sendInstr(makeInstr(6'h1f, 5'd0, 5'd4, 5'd3, 5'd24, 6'h20), 0);
        sendInstr(makeInstr(6'h1f, 5'd0, 5'd4, 5'd3, 5'd16, 6'h20), 0);
        sendInstr(makeInstr(6'h1f, 5'd0, 5'd4, 5'd3, 5'd7, 6'h20), 0);

        // Every opcode, then the regimm rt choice
        for (int op = 0; op < 64; op++) begin
            sendInstr(makeInstr(op[5:0], 5'd2, 5'd1, 5'd3, 5'd4, 6'h21), 1);
        end
        sendInstr(makeInstr(6'h01, 5'd2, 5'd0, 5'd0, 5'd0, 6'h10), 0);   // bltz
        sendInstr(makeInstr(6'h01, 5'd2, 5'd5, 5'd0, 5'd0, 6'h10), 0);
        sendInstr('0, 2);                                                // nop

        // Long holds before req drops
        sendInstr(makeInstr(6'h23, 5'd2, 5'd1, 5'd0, 5'd0, 6'h04), 20);
        sendInstr(makeInstr(6'h00, 5'd2, 5'd4, 5'd3, 5'd0, 6'h18), 25);

        for (int i = 0; i < 400; i++) begin
            hold = $random(seed) & 7;
            sendInstr($random(seed), hold);
        end
        finishRun();
    end

endmodule

// ==== src.f ====
src/ctrlPkg.sv
src/functDecoder.sv
src/opcodeDecoder.sv
src/controlUnit.sv
sim/tbControlUnit.sv
+incdir+sim

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := tbControlUnit
FILELIST  := src.f
OBJDIR    := obj_dir
SIMBIN    := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) sim/tbRefModel.svh

.PHONY: all run clean

all: run

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIMBIN)
	@out="$$(./$(SIMBIN))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJDIR)
